//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    // ########################################
    // single-beat AXI-lite style bus
    // ########################################

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  resp_t;

    // transfer size is log2 of the byte count
    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    // on-chip SRAM window, everything else answers with an error
    localparam bus_pkg::addr_t MEM_BASE = 32'h8000_0000;
    localparam int MEM_WORDS = 256;

    // load/store operations seen by the LSU
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_t;

endpackage

`default_nettype wire

//--- lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  mem_pkg::mem_op_t req_op,
    input  bus_pkg::addr_t   req_addr,
    input  bus_pkg::data_t   req_wdata,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output bus_pkg::data_t   rsp_rdata,
    output logic             rsp_fault,
    output logic             arvalid,
    input  logic             arready,
    output bus_pkg::addr_t   araddr,
    output bus_pkg::size_t   arsize,
    input  logic             rvalid,
    output logic             rready,
    input  bus_pkg::data_t   rdata,
    input  bus_pkg::resp_t   rresp,
    output logic             awvalid,
    input  logic             awready,
    output bus_pkg::addr_t   awaddr,
    output bus_pkg::size_t   awsize,
    output logic             wvalid,
    input  logic             wready,
    output bus_pkg::data_t   wdata,
    output bus_pkg::strb_t   wstrb,
    input  logic             bvalid,
    output logic             bready,
    input  bus_pkg::resp_t   bresp
);
    typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_t;

    state_t           state;
    state_t           next_state;
    mem_pkg::mem_op_t op_q;
    bus_pkg::addr_t   addr_q;
    bus_pkg::size_t   size_q;
    logic             store_q;
    logic             accept;
    logic             req_store;
    logic             req_misalign;
    logic [1:0]       req_off;
    bus_pkg::size_t   req_size;
    bus_pkg::strb_t   strb_base;
    bus_pkg::data_t   lane;
    bus_pkg::data_t   load_data;

    // ########################################
    // request decode
    // ########################################

    assign accept    = req_valid && req_ready;
    assign req_off   = req_addr[1:0];
    assign req_store = (req_op == mem_pkg::SB) || (req_op == mem_pkg::SH) ||
                       (req_op == mem_pkg::SW);

    always_comb begin
        case (req_op)
            mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: begin
                req_size  = bus_pkg::SIZE_BYTE;
                strb_base = 4'b0001;
            end
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: begin
                req_size  = bus_pkg::SIZE_HALF;
                strb_base = 4'b0011;
            end
            default: begin
                req_size  = bus_pkg::SIZE_WORD;
                strb_base = 4'b1111;
            end
        endcase
    end

    assign req_misalign = ((req_size == bus_pkg::SIZE_HALF) && req_off[0]) ||
                          ((req_size == bus_pkg::SIZE_WORD) && (req_off != 2'b00));

    // ########################################
    // control
    // ########################################

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = req_misalign ? DONE : ADDR;
                end
            end
            ADDR: begin
                if (store_q ? ((!awvalid || awready) && (!wvalid || wready)) : arready) begin
                    next_state = RESP;
                end
            end
            RESP: begin
                if ((rvalid && rready) || (bvalid && bready)) begin
                    next_state = DONE;
                end
            end
            default: begin
                if (rsp_ready) begin
                    next_state = IDLE;
                end
            end
        endcase
    end

    // address and data stay up independently until each is taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            req_ready <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
        end else begin
            state     <= next_state;
            req_ready <= (next_state == IDLE);
            if (accept) begin
                awvalid <= req_store && !req_misalign;
                wvalid  <= req_store && !req_misalign;
            end else begin
                if (awready) begin
                    awvalid <= 1'b0;
                end
                if (wready) begin
                    wvalid <= 1'b0;
                end
            end
        end
    end

    assign arvalid   = (state == ADDR) && !store_q;
    assign rready    = (state == RESP) && !store_q;
    assign bready    = (state == RESP) && store_q;
    assign rsp_valid = (state == DONE);
    assign araddr    = addr_q;
    assign awaddr    = addr_q;
    assign arsize    = size_q;
    assign awsize    = size_q;

    // ########################################
    // payload
    // ########################################

    always_comb begin
        lane = rdata >> {addr_q[1:0], 3'b000};
        case (op_q)
            mem_pkg::LB:  load_data = {{24{lane[7]}}, lane[7:0]};
            mem_pkg::LBU: load_data = {24'b0, lane[7:0]};
            mem_pkg::LH:  load_data = {{16{lane[15]}}, lane[15:0]};
            mem_pkg::LHU: load_data = {16'b0, lane[15:0]};
            default:      load_data = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= req_op;
            addr_q    <= req_addr;
            size_q    <= req_size;
            store_q   <= req_store;
            wdata     <= req_wdata << {req_off, 3'b000};
            wstrb     <= strb_base << req_off;
            rsp_rdata <= '0;
            rsp_fault <= req_misalign;
        end
        if (rvalid && rready) begin
            rsp_rdata <= load_data;
            rsp_fault <= (rresp != bus_pkg::RESP_OKAY);
        end
        if (bvalid && bready) begin
            rsp_fault <= (bresp != bus_pkg::RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_valid,
    output logic           fetch_ready,
    input  bus_pkg::addr_t fetch_addr,
    output logic           inst_valid,
    input  logic           inst_ready,
    output bus_pkg::data_t inst,
    output logic           inst_fault,
    output logic           arvalid,
    input  logic           arready,
    output bus_pkg::addr_t araddr,
    output bus_pkg::size_t arsize,
    input  logic           rvalid,
    output logic           rready,
    input  bus_pkg::data_t rdata,
    input  bus_pkg::resp_t rresp
);
    typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_t;

    state_t         state;
    state_t         next_state;
    bus_pkg::addr_t addr_q;
    logic           accept;
    logic           misalign;

    assign accept   = fetch_valid && fetch_ready;
    assign misalign = (fetch_addr[1:0] != 2'b00);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = accept ? (misalign ? DONE : ADDR) : IDLE;
            ADDR:    next_state = arready ? RESP : ADDR;
            RESP:    next_state = rvalid ? DONE : RESP;
            default: next_state = inst_ready ? IDLE : DONE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            fetch_ready <= 1'b0;
        end else begin
            state       <= next_state;
            fetch_ready <= (next_state == IDLE);
        end
    end

    assign arvalid    = (state == ADDR);
    assign rready     = (state == RESP);
    assign inst_valid = (state == DONE);
    assign araddr     = addr_q;
    assign arsize     = bus_pkg::SIZE_WORD;

    // instruction word is held here until the consumer takes it
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= fetch_addr;
            inst       <= '0;
            inst_fault <= misalign;
        end
        if (rvalid && rready) begin
            inst       <= rdata;
            inst_fault <= (rresp != bus_pkg::RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           lsu_arvalid,
    output logic           lsu_arready,
    input  bus_pkg::addr_t lsu_araddr,
    input  bus_pkg::size_t lsu_arsize,
    output logic           lsu_rvalid,
    input  logic           lsu_rready,
    output bus_pkg::data_t lsu_rdata,
    output bus_pkg::resp_t lsu_rresp,
    input  logic           lsu_awvalid,
    output logic           lsu_awready,
    input  bus_pkg::addr_t lsu_awaddr,
    input  bus_pkg::size_t lsu_awsize,
    input  logic           lsu_wvalid,
    output logic           lsu_wready,
    input  bus_pkg::data_t lsu_wdata,
    input  bus_pkg::strb_t lsu_wstrb,
    output logic           lsu_bvalid,
    input  logic           lsu_bready,
    output bus_pkg::resp_t lsu_bresp,
    input  logic           fetch_arvalid,
    output logic           fetch_arready,
    input  bus_pkg::addr_t fetch_araddr,
    input  bus_pkg::size_t fetch_arsize,
    output logic           fetch_rvalid,
    input  logic           fetch_rready,
    output bus_pkg::data_t fetch_rdata,
    output bus_pkg::resp_t fetch_rresp,
    // memory side
    output logic           arvalid,
    input  logic           arready,
    output bus_pkg::addr_t araddr,
    output bus_pkg::size_t arsize,
    input  logic           rvalid,
    output logic           rready,
    input  bus_pkg::data_t rdata,
    input  bus_pkg::resp_t rresp,
    output logic           awvalid,
    input  logic           awready,
    output bus_pkg::addr_t awaddr,
    output bus_pkg::size_t awsize,
    output logic           wvalid,
    input  logic           wready,
    output bus_pkg::data_t wdata,
    output bus_pkg::strb_t wstrb,
    input  logic           bvalid,
    output logic           bready,
    input  bus_pkg::resp_t bresp
);
    typedef enum logic [1:0] {NONE, LSU, FETCH} owner_t;

    owner_t owner;
    owner_t sel;
    logic   last_fetch;
    logic   lsu_req;
    logic   fetch_req;
    logic   release_bus;

    assign lsu_req     = lsu_arvalid || lsu_awvalid;
    assign fetch_req   = fetch_arvalid;
    assign release_bus = (rvalid && rready) || (bvalid && bready);

    // a held owner wins, otherwise the requester not served last
    always_comb begin
        sel = owner;
        if (owner == NONE) begin
            if (lsu_req && fetch_req) begin
                sel = last_fetch ? LSU : FETCH;
            end else if (lsu_req) begin
                sel = LSU;
            end else if (fetch_req) begin
                sel = FETCH;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner      <= NONE;
            last_fetch <= 1'b0;
        end else if ((owner == NONE) && (sel != NONE)) begin
            owner      <= sel;
            last_fetch <= (sel == FETCH);
        end else if (release_bus) begin
            owner <= NONE;
        end
    end

    // ########################################
    // channel steering
    // ########################################

    assign araddr = (sel == FETCH) ? fetch_araddr : lsu_araddr;
    assign arsize = (sel == FETCH) ? fetch_arsize : lsu_arsize;
    assign awaddr = lsu_awaddr;
    assign awsize = lsu_awsize;
    assign wdata  = lsu_wdata;
    assign wstrb  = lsu_wstrb;

    assign arvalid = (sel == LSU) ? lsu_arvalid : (sel == FETCH) && fetch_arvalid;
    assign rready  = (sel == LSU) ? lsu_rready : (sel == FETCH) && fetch_rready;
    assign awvalid = (sel == LSU) && lsu_awvalid;
    assign wvalid  = (sel == LSU) && lsu_wvalid;
    assign bready  = (sel == LSU) && lsu_bready;

    assign lsu_arready   = (sel == LSU) && arready;
    assign lsu_rvalid    = (sel == LSU) && rvalid;
    assign lsu_awready   = (sel == LSU) && awready;
    assign lsu_wready    = (sel == LSU) && wready;
    assign lsu_bvalid    = (sel == LSU) && bvalid;
    assign fetch_arready = (sel == FETCH) && arready;
    assign fetch_rvalid  = (sel == FETCH) && rvalid;

    assign lsu_rdata   = rdata;
    assign lsu_rresp   = rresp;
    assign lsu_bresp   = bresp;
    assign fetch_rdata = rdata;
    assign fetch_rresp = rresp;

endmodule

`default_nettype wire

//--- sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

module sram_slave (
    input  logic           clk,
    input  logic           rst,
    input  logic           arvalid,
    output logic           arready,
    input  bus_pkg::addr_t araddr,
    input  bus_pkg::size_t arsize,
    output logic           rvalid,
    input  logic           rready,
    output bus_pkg::data_t rdata,
    output bus_pkg::resp_t rresp,
    input  logic           awvalid,
    output logic           awready,
    input  bus_pkg::addr_t awaddr,
    input  bus_pkg::size_t awsize,
    input  logic           wvalid,
    output logic           wready,
    input  bus_pkg::data_t wdata,
    input  bus_pkg::strb_t wstrb,
    output logic           bvalid,
    input  logic           bready,
    output bus_pkg::resp_t bresp
);
    localparam int IDX_W = $clog2(mem_pkg::MEM_WORDS);
    localparam bus_pkg::addr_t MEM_BYTES = bus_pkg::addr_t'(mem_pkg::MEM_WORDS * 4);

    bus_pkg::data_t   mem [mem_pkg::MEM_WORDS];
    bus_pkg::addr_t   rd_off;
    bus_pkg::addr_t   wr_off;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             rd_hit;
    logic             wr_hit;
    logic             rd_fire;
    logic             wr_fire;

    // addresses below the base wrap to a large offset and miss as well
    assign rd_off = araddr - mem_pkg::MEM_BASE;
    assign wr_off = awaddr - mem_pkg::MEM_BASE;
    assign rd_idx = rd_off[IDX_W+1:2];
    assign wr_idx = wr_off[IDX_W+1:2];
    assign rd_hit = (rd_off < MEM_BYTES) && (arsize <= bus_pkg::SIZE_WORD);
    assign wr_hit = (wr_off < MEM_BYTES) && (awsize <= bus_pkg::SIZE_WORD);

    // a write is taken only with address and data together
    assign arready = !rvalid;
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign rd_fire = arvalid && arready;
    assign wr_fire = awready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_hit ? mem[rd_idx] : '0;
            rresp <= rd_hit ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
        end
        if (wr_fire) begin
            bresp <= wr_hit ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
            for (int b = 0; b < 4; b++) begin
                if (wr_hit && wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  mem_pkg::mem_op_t req_op,
    input  bus_pkg::addr_t   req_addr,
    input  bus_pkg::data_t   req_wdata,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output bus_pkg::data_t   rsp_rdata,
    output logic             rsp_fault,
    input  logic             fetch_valid,
    output logic             fetch_ready,
    input  bus_pkg::addr_t   fetch_addr,
    output logic             inst_valid,
    input  logic             inst_ready,
    output bus_pkg::data_t   inst,
    output logic             inst_fault
);
    // ########################################
    // requester side of the arbiter
    // ########################################

    logic           lsu_arvalid, lsu_arready;
    bus_pkg::addr_t lsu_araddr;
    bus_pkg::size_t lsu_arsize;
    logic           lsu_rvalid, lsu_rready;
    bus_pkg::data_t lsu_rdata;
    bus_pkg::resp_t lsu_rresp;
    logic           lsu_awvalid, lsu_awready;
    bus_pkg::addr_t lsu_awaddr;
    bus_pkg::size_t lsu_awsize;
    logic           lsu_wvalid, lsu_wready;
    bus_pkg::data_t lsu_wdata;
    bus_pkg::strb_t lsu_wstrb;
    logic           lsu_bvalid, lsu_bready;
    bus_pkg::resp_t lsu_bresp;
    logic           fetch_arvalid, fetch_arready;
    bus_pkg::addr_t fetch_araddr;
    bus_pkg::size_t fetch_arsize;
    logic           fetch_rvalid, fetch_rready;
    bus_pkg::data_t fetch_rdata;
    bus_pkg::resp_t fetch_rresp;

    // ########################################
    // memory side
    // ########################################

    logic           arvalid, arready;
    bus_pkg::addr_t araddr;
    bus_pkg::size_t arsize;
    logic           rvalid, rready;
    bus_pkg::data_t rdata;
    bus_pkg::resp_t rresp;
    logic           awvalid, awready;
    bus_pkg::addr_t awaddr;
    bus_pkg::size_t awsize;
    logic           wvalid, wready;
    bus_pkg::data_t wdata;
    bus_pkg::strb_t wstrb;
    logic           bvalid, bready;
    bus_pkg::resp_t bresp;

    lsu u_lsu (
        .*,
        .arvalid (lsu_arvalid),
        .arready (lsu_arready),
        .araddr  (lsu_araddr),
        .arsize  (lsu_arsize),
        .rvalid  (lsu_rvalid),
        .rready  (lsu_rready),
        .rdata   (lsu_rdata),
        .rresp   (lsu_rresp),
        .awvalid (lsu_awvalid),
        .awready (lsu_awready),
        .awaddr  (lsu_awaddr),
        .awsize  (lsu_awsize),
        .wvalid  (lsu_wvalid),
        .wready  (lsu_wready),
        .wdata   (lsu_wdata),
        .wstrb   (lsu_wstrb),
        .bvalid  (lsu_bvalid),
        .bready  (lsu_bready),
        .bresp   (lsu_bresp)
    );

    fetch_unit u_fetch (
        .*,
        .arvalid (fetch_arvalid),
        .arready (fetch_arready),
        .araddr  (fetch_araddr),
        .arsize  (fetch_arsize),
        .rvalid  (fetch_rvalid),
        .rready  (fetch_rready),
        .rdata   (fetch_rdata),
        .rresp   (fetch_rresp)
    );

    bus_arbiter u_arbiter (.*);

    sram_slave u_sram (.*);

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

    localparam int WAIT_LIMIT = 200;
    localparam bus_pkg::addr_t MEM_BYTES = bus_pkg::addr_t'(mem_pkg::MEM_WORDS * 4);

    logic             clk;
    logic             rst;
    logic             req_valid;
    logic             req_ready;
    mem_pkg::mem_op_t req_op;
    bus_pkg::addr_t   req_addr;
    bus_pkg::data_t   req_wdata;
    logic             rsp_valid;
    logic             rsp_ready;
    bus_pkg::data_t   rsp_rdata;
    logic             rsp_fault;
    logic             fetch_valid;
    logic             fetch_ready;
    bus_pkg::addr_t   fetch_addr;
    logic             inst_valid;
    logic             inst_ready;
    bus_pkg::data_t   inst;
    logic             inst_fault;

    // byte image of the SRAM window
    logic [7:0]     ref_mem [mem_pkg::MEM_WORDS * 4];
    bus_pkg::data_t exp_rdata;
    logic           exp_fault;
    bus_pkg::data_t exp_inst;
    logic           exp_inst_fault;
    logic [31:0]    rng = 32'hfca1_196e;
    int             errors = 0;
    int             n_rsp = 0;
    int             n_inst = 0;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    mem_subsys uut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_rdata   (rsp_rdata),
        .rsp_fault   (rsp_fault),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .inst_fault  (inst_fault)
    );

    // ########################################
    // response checks
    // ########################################

    // a response must match from the cycle it shows up until it is taken
    rsp_data_check: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (rsp_rdata == exp_rdata))
    else begin
        errors++;
        $display("FAILED rsp_rdata got %h expected %h", rsp_rdata, exp_rdata);
    end

    rsp_fault_check: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (rsp_fault == exp_fault))
    else begin
        errors++;
        $display("FAILED rsp_fault got %h expected %h", rsp_fault, exp_fault);
    end

    rsp_hold_check: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid)
    else begin
        errors++;
        $display("rsp_valid dropped before the response was taken");
    end

    // no new request is taken while a response waits
    req_block_check: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !req_ready)
    else begin
        errors++;
        $display("FAILED req_ready got %h expected %h", req_ready, 1'b0);
    end

    inst_data_check: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> (inst == exp_inst))
    else begin
        errors++;
        $display("FAILED inst got %h expected %h", inst, exp_inst);
    end

    inst_fault_check: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> (inst_fault == exp_inst_fault))
    else begin
        errors++;
        $display("FAILED inst_fault got %h expected %h", inst_fault, exp_inst_fault);
    end

    inst_hold_check: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> inst_valid)
    else begin
        errors++;
        $display("inst_valid dropped before the instruction was taken");
    end

    fetch_block_check: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> !fetch_ready)
    else begin
        errors++;
        $display("FAILED fetch_ready got %h expected %h", fetch_ready, 1'b0);
    end

    // ########################################
    // reference model
    // ########################################

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic draw_ready();
        logic [31:0] r;
        r = next_random();
        return r[0];
    endfunction

    function automatic bus_pkg::addr_t word_addr(input logic [7:0] idx);
        return mem_pkg::MEM_BASE + {22'b0, idx, 2'b00};
    endfunction

    function automatic bus_pkg::data_t fill_value(input bus_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic bus_pkg::data_t read_ref_word(input logic [9:0] base);
        return {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                ref_mem[base + 10'd1], ref_mem[base]};
    endfunction

    // sets the expected response and applies a legal store to the image
    function automatic void predict_access(input mem_pkg::mem_op_t op,
                                           input bus_pkg::addr_t addr,
                                           input bus_pkg::data_t wd);
        int             nbytes;
        int             b;
        logic           store;
        logic           signed_load;
        bus_pkg::addr_t off;
        case (op)
            mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: nbytes = 1;
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: nbytes = 2;
            default: nbytes = 4;
        endcase
        store = (op == mem_pkg::SB) || (op == mem_pkg::SH) || (op == mem_pkg::SW);
        signed_load = (op == mem_pkg::LB) || (op == mem_pkg::LH);
        off = addr - mem_pkg::MEM_BASE;
        exp_rdata = '0;
        exp_fault = ((nbytes == 2) && addr[0]) || ((nbytes == 4) && (addr[1:0] != 2'b00)) ||
                    (off >= MEM_BYTES);
        if (!exp_fault) begin
            for (b = 0; b < nbytes; b++) begin
                if (store) begin
                    ref_mem[off[9:0] + 10'(b)] = wd[8*b +: 8];
                end else begin
                    exp_rdata[8*b +: 8] = ref_mem[off[9:0] + 10'(b)];
                end
            end
            // the top bit of the highest loaded byte fills the rest of a signed load
            if (!store && signed_load && exp_rdata[8*nbytes-1]) begin
                exp_rdata = exp_rdata | ~((32'd1 << (8*nbytes)) - 32'd1);
            end
        end
    endfunction

    function automatic void predict_fetch(input bus_pkg::addr_t addr);
        bus_pkg::addr_t off;
        off = addr - mem_pkg::MEM_BASE;
        exp_inst_fault = (addr[1:0] != 2'b00) || (off >= MEM_BYTES);
        exp_inst = exp_inst_fault ? '0 : read_ref_word(off[9:0]);
    endfunction

    // ########################################
    // drivers
    // ########################################

    task automatic print_counts();
        $display("lsu responses %0d, fetch responses %0d, errors %0d", n_rsp, n_inst, errors);
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    task automatic lsu_access(input mem_pkg::mem_op_t op, input bus_pkg::addr_t addr,
                              input bus_pkg::data_t wd);
        int cnt;
        predict_access(op, addr, wd);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wd;
        cnt = 0;
        @(negedge clk);
        while (!req_ready) begin
            if (cnt == WAIT_LIMIT) abort_run("load/store request was not accepted in time");
            @(negedge clk);
            cnt++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        rsp_ready = draw_ready();
        cnt = 0;
        @(negedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            if (cnt == WAIT_LIMIT) abort_run("load/store response did not arrive in time");
            @(posedge clk);
            #1;
            rsp_ready = draw_ready();
            @(negedge clk);
            cnt++;
        end
        @(posedge clk);
        #1;
        rsp_ready = 1'b0;
        n_rsp++;
    endtask

    task automatic fetch_word(input bus_pkg::addr_t addr);
        int cnt;
        predict_fetch(addr);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        cnt = 0;
        @(negedge clk);
        while (!fetch_ready) begin
            if (cnt == WAIT_LIMIT) abort_run("fetch request was not accepted in time");
            @(negedge clk);
            cnt++;
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        inst_ready  = draw_ready();
        cnt = 0;
        @(negedge clk);
        while (!(inst_valid && inst_ready)) begin
            if (cnt == WAIT_LIMIT) abort_run("instruction did not arrive in time");
            @(posedge clk);
            #1;
            inst_ready = draw_ready();
            @(negedge clk);
            cnt++;
        end
        @(posedge clk);
        #1;
        inst_ready = 1'b0;
        n_inst++;
    endtask

    // one byte or half store, then every load flavour on the same word
    task automatic partial_rw(input int count);
        logic [31:0]    r;
        bus_pkg::addr_t a;
        repeat (count) begin
            r = next_random();
            a = word_addr(r[7:0]);
            if (r[8]) begin
                lsu_access(mem_pkg::SB, a + {30'b0, r[10:9]}, next_random());
            end else begin
                lsu_access(mem_pkg::SH, a + {30'b0, r[10], 1'b0}, next_random());
            end
            lsu_access(mem_pkg::LB, a + {30'b0, r[12:11]}, '0);
            lsu_access(mem_pkg::LBU, a + {30'b0, r[14:13]}, '0);
            lsu_access(mem_pkg::LH, a + {30'b0, r[15], 1'b0}, '0);
            lsu_access(mem_pkg::LHU, a + {30'b0, r[16], 1'b0}, '0);
            lsu_access(mem_pkg::LW, a, '0);
        end
    endtask

    // stores stay in the upper half so fetched words never change
    task automatic mixed_traffic(input int count);
        logic [31:0]      r;
        mem_pkg::mem_op_t op;
        bus_pkg::addr_t   a;
        repeat (count) begin
            r  = next_random();
            op = mem_pkg::mem_op_t'(r[2:0]);
            if ((op == mem_pkg::SB) || (op == mem_pkg::SH) || (op == mem_pkg::SW)) begin
                a = word_addr({1'b1, r[9:3]}) + {30'b0, r[12:11]};
            end else begin
                a = word_addr(r[10:3]) + {30'b0, r[12:11]};
            end
            lsu_access(op, a, next_random());
        end
    endtask

    task automatic fetch_stream(input int count);
        logic [31:0] r;
        repeat (count) begin
            r = next_random();
            fetch_word(word_addr({1'b0, r[6:0]}));
        end
    endtask

    // ########################################
    // test sequence
    // ########################################

    initial begin
        logic [31:0]    r;
        bus_pkg::addr_t a;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = mem_pkg::LW;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        inst_ready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            lsu_access(mem_pkg::SW, word_addr(8'(i)), fill_value(word_addr(8'(i))));
        end

        repeat (8) begin
            r = next_random();
            a = word_addr(r[7:0]);
            lsu_access(mem_pkg::SW, a, next_random());
            lsu_access(mem_pkg::LW, a, '0);
        end

        partial_rw(30);

        // just past each end of the window, where a short decode would alias
        lsu_access(mem_pkg::SW, mem_pkg::MEM_BASE + MEM_BYTES, next_random());
        lsu_access(mem_pkg::SB, mem_pkg::MEM_BASE - 32'd1, next_random());
        lsu_access(mem_pkg::LW, 32'h0000_1000, '0);
        fetch_word(32'h0000_2000);
        lsu_access(mem_pkg::LW, word_addr(8'h00), '0);
        lsu_access(mem_pkg::LW, word_addr(8'hff), '0);

        r = next_random();
        a = word_addr(r[7:0]);
        lsu_access(mem_pkg::LH, a + 32'd3, '0);
        lsu_access(mem_pkg::LW, a + 32'd2, '0);
        lsu_access(mem_pkg::SW, a + 32'd2, next_random());
        fetch_word(a + 32'd1);
        lsu_access(mem_pkg::LW, a, '0);

        fork
            mixed_traffic(80);
            fetch_stream(80);
        join

        print_counts();
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
bus_pkg.sv
mem_pkg.sv
lsu.sv
fetch_unit.sv
bus_arbiter.sv
sram_slave.sv
mem_subsys.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_mem_subsys \
    -f flist.f > build.log 2>&1 \
    && ./obj_dir/Vtb_mem_subsys > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
